// File: Makefile
# Verilator build and run for the load/store unit testbench
VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
EXTRA     ?=

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
rtl/lsu_pkg.sv
rtl/lsu_request_queue.sv
rtl/lsu_mem_stage.sv
rtl/lsu_load_return.sv
rtl/lsu_top.sv
tb/lsu_props.sv
tb/tb_lsu.sv

// File: rtl/lsu_load_return.sv
`timescale 1ns/1ps

module lsu_load_return (
  input  logic             clk,
  input  logic             nrst,
  input  logic             load_issue,
  input  logic             load_valid,
  input  lsu_pkg::mem_op_e load_op,
  input  logic [1:0]       load_lane,
  input  lsu_pkg::word_t   load_word,
  input  logic             rsp_credit,
  output logic             load_room,
  output logic             rsp_valid,
  output lsu_pkg::word_t   rsp_data
);
  import lsu_pkg::*;

  logic [RSP_CNT_W-1:0] credit_cnt;
  logic [7:0]           lane_byte;
  logic [15:0]          lane_half;
  word_t                load_ext;

  // Byte by both lane bits, half by bit 1 only
  assign lane_byte = load_word[load_lane*8 +: 8];
  assign lane_half = load_lane[1] ? load_word[31:16] : load_word[15:0];

  always_comb begin
    case (load_op)
      OP_LB:   load_ext = {{24{lane_byte[7]}}, lane_byte};
      OP_LBU:  load_ext = {24'b0, lane_byte};
      OP_LH:   load_ext = {{16{lane_half[15]}}, lane_half};
      OP_LHU:  load_ext = {16'b0, lane_half};
      default: load_ext = load_word;
    endcase
  end

  // Response register
  always_ff @(posedge clk) begin
    if (load_valid) begin
      rsp_data <= load_ext;
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= load_valid;
    end
  end

  // Spent when a load issues, so the slot is held through the pipe
  always_ff @(posedge clk) begin
    if (!nrst) begin
      credit_cnt <= RSP_CNT_W'(RSP_CREDITS);
    end else begin
      case ({load_issue, rsp_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  assign load_room = (credit_cnt != '0);

endmodule

// File: rtl/lsu_mem_stage.sv
`timescale 1ns/1ps

module lsu_mem_stage (
  input  logic             clk,
  input  logic             nrst,
  input  logic             head_valid,
  input  lsu_pkg::mem_op_e head_op,
  input  lsu_pkg::word_t   head_addr,
  input  lsu_pkg::word_t   head_wdata,
  input  logic             load_room,
  output logic             pop,
  output logic             load_issue,
  output logic             load_valid,
  output lsu_pkg::mem_op_e load_op,
  output logic [1:0]       load_lane,
  output lsu_pkg::word_t   load_word
);
  import lsu_pkg::*;

  // Backing store, no reset
  word_t dmem [DMEM_WORDS];

  logic               is_load;
  logic               store_en;
  logic [DMEM_AW-1:0] word_idx;
  word_t              store_data;
  byte_en_t           store_be;

  always_comb begin
    case (head_op)
      OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: is_load = 1'b1;
      default:                             is_load = 1'b0;
    endcase
  end

  // Stores go without credits, loads need room on the return side
  assign pop        = head_valid && (!is_load || load_room);
  assign load_issue = pop && is_load;
  assign store_en   = pop && !is_load;

  // Upper address bits are ignored
  assign word_idx = head_addr[DMEM_AW+1:2];

  // Store lane alignment
  always_comb begin
    case (head_op)
      OP_SB: begin
        // Byte goes to every lane, the enable picks one
        store_data = {4{head_wdata[7:0]}};
        store_be   = byte_en_t'(1) << head_addr[1:0];
      end
      OP_SH: begin
        // Only bit 1 picks the half
        store_data = {2{head_wdata[15:0]}};
        store_be   = head_addr[1] ? 4'b1100 : 4'b0011;
      end
      OP_SW: begin
        store_data = head_wdata;
        store_be   = 4'b1111;
      end
      default: begin
        store_data = head_wdata;
        store_be   = '0;
      end
    endcase
  end

  // Byte-enabled write, lane by lane
  always_ff @(posedge clk) begin
    if (store_en) begin
      for (int i = 0; i < $bits(byte_en_t); i++) begin
        if (store_be[i]) begin
          dmem[word_idx][i*8 +: 8] <= store_data[i*8 +: 8];
        end
      end
    end
  end

  // Synchronous read with op and lane alongside
  always_ff @(posedge clk) begin
    if (load_issue) begin
      load_word <= dmem[word_idx];
      load_op   <= head_op;
      load_lane <= head_addr[1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      load_valid <= 1'b0;
    end else begin
      load_valid <= load_issue;
    end
  end

endmodule

// File: rtl/lsu_pkg.sv
package lsu_pkg;

  // Data word, also used for byte addresses
  typedef logic [31:0] word_t;

  // One write enable per byte lane
  typedef logic [3:0] byte_en_t;

  // Load and store operations
  typedef enum logic [2:0] {
    OP_LB  = 3'd0,
    OP_LH  = 3'd1,
    OP_LW  = 3'd2,
    OP_LBU = 3'd3,
    OP_LHU = 3'd4,
    OP_SB  = 3'd5,
    OP_SH  = 3'd6,
    OP_SW  = 3'd7
  } mem_op_e;

  // Input queue, entries equal the requester's credits after reset
  localparam int REQ_DEPTH = 4;
  localparam int REQ_PTR_W = 2;

  // Response credits held by the DUT after reset
  localparam int RSP_CREDITS = 2;
  localparam int RSP_CNT_W   = 2;

  // Data memory, address bits 7:2 select the word
  localparam int DMEM_WORDS = 64;
  localparam int DMEM_AW    = 6;

endpackage

// File: rtl/lsu_request_queue.sv
`timescale 1ns/1ps

module lsu_request_queue (
  input  logic            clk,
  input  logic            nrst,
  input  logic            req_valid,
  input  lsu_pkg::mem_op_e req_op,
  input  lsu_pkg::word_t  req_addr,
  input  lsu_pkg::word_t  req_wdata,
  input  logic            pop,
  output logic            head_valid,
  output lsu_pkg::mem_op_e head_op,
  output lsu_pkg::word_t  head_addr,
  output lsu_pkg::word_t  head_wdata,
  output logic            req_credit
);
  import lsu_pkg::*;

  // Entry storage, payload only
  mem_op_e op_q    [REQ_DEPTH];
  word_t   addr_q  [REQ_DEPTH];
  word_t   wdata_q [REQ_DEPTH];

  logic [REQ_PTR_W-1:0] wr_ptr;
  logic [REQ_PTR_W-1:0] rd_ptr;
  logic [REQ_PTR_W:0]   count;
  logic                 full;
  logic                 push;

  // Depth is a power of two, so the count MSB marks full
  assign full = count[REQ_PTR_W];
  assign push = req_valid && !full;

  always_ff @(posedge clk) begin
    if (push) begin
      op_q[wr_ptr]    <= req_op;
      addr_q[wr_ptr]  <= req_addr;
      wdata_q[wr_ptr] <= req_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head entry straight from storage
  assign head_valid = (count != '0);
  assign head_op    = op_q[rd_ptr];
  assign head_addr  = addr_q[rd_ptr];
  assign head_wdata = wdata_q[rd_ptr];

  // One credit back per entry taken
  assign req_credit = pop;

endmodule

// File: rtl/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
  input  logic             clk,
  input  logic             nrst,
  input  logic             req_valid,
  input  lsu_pkg::mem_op_e req_op,
  input  lsu_pkg::word_t   req_addr,
  input  lsu_pkg::word_t   req_wdata,
  input  logic             rsp_credit,
  output logic             req_credit,
  output logic             rsp_valid,
  output lsu_pkg::word_t   rsp_data
);
  import lsu_pkg::*;

  // Queue head
  logic    head_valid;
  mem_op_e head_op;
  word_t   head_addr;
  word_t   head_wdata;
  logic    pop;

  // Memory stage to return side
  logic       load_room;
  logic       load_issue;
  logic       load_valid;
  mem_op_e    load_op;
  logic [1:0] load_lane;
  word_t      load_word;

  lsu_request_queue u_request_queue (
    .clk        (clk),
    .nrst       (nrst),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .pop        (pop),
    .head_valid (head_valid),
    .head_op    (head_op),
    .head_addr  (head_addr),
    .head_wdata (head_wdata),
    .req_credit (req_credit)
  );

  lsu_mem_stage u_mem_stage (
    .clk        (clk),
    .nrst       (nrst),
    .head_valid (head_valid),
    .head_op    (head_op),
    .head_addr  (head_addr),
    .head_wdata (head_wdata),
    .load_room  (load_room),
    .pop        (pop),
    .load_issue (load_issue),
    .load_valid (load_valid),
    .load_op    (load_op),
    .load_lane  (load_lane),
    .load_word  (load_word)
  );

  lsu_load_return u_load_return (
    .clk        (clk),
    .nrst       (nrst),
    .load_issue (load_issue),
    .load_valid (load_valid),
    .load_op    (load_op),
    .load_lane  (load_lane),
    .load_word  (load_word),
    .rsp_credit (rsp_credit),
    .load_room  (load_room),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data)
  );

endmodule

// File: tb/lsu_props.sv
`timescale 1ns/1ps

module lsu_props (
  input logic                        clk,
  input logic                        nrst,
  input logic                        req_valid,
  input logic                        queue_full,
  input logic [lsu_pkg::RSP_CNT_W-1:0] credit_cnt,
  input logic                        load_valid,
  input logic                        rsp_valid,
  input logic                        req_credit,
  input logic                        head_valid
);
  import lsu_pkg::*;

  // Requester must respect its input credits
  a_no_push_full: assert property (@(posedge clk) disable iff (!nrst)
    queue_full |-> !req_valid)
    else $error("request pushed into a full queue");

  a_credit_max: assert property (@(posedge clk) disable iff (!nrst)
    credit_cnt <= RSP_CREDITS)
    else $error("response credit counter above its reset value");

  // Return side adds exactly one register
  a_rsp_follows: assert property (@(posedge clk) disable iff (!nrst)
    load_valid |=> rsp_valid)
    else $error("rsp_valid missing one cycle after load_valid");

  a_credit_head: assert property (@(posedge clk) disable iff (!nrst)
    req_credit |-> head_valid)
    else $error("req_credit without a valid queue head");

endmodule

bind lsu_top lsu_props u_lsu_props (
  .clk        (clk),
  .nrst       (nrst),
  .req_valid  (req_valid),
  .queue_full (u_request_queue.full),
  .credit_cnt (u_load_return.credit_cnt),
  .load_valid (load_valid),
  .rsp_valid  (rsp_valid),
  .req_credit (req_credit),
  .head_valid (head_valid)
);

// File: tb/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;
  import lsu_pkg::*;

  localparam int WAIT_LIMIT = 400;

  logic    clk;
  logic    nrst;
  logic    req_valid;
  mem_op_e req_op;
  word_t   req_addr;
  word_t   req_wdata;
  logic    rsp_credit;
  logic    req_credit;
  logic    rsp_valid;
  word_t   rsp_data;

  // Reference memory and response queues
  word_t model_mem [DMEM_WORDS];
  word_t exp_q [$];
  word_t got_q [$];

  int req_sent;
  int req_back;
  int loads_sent;
  int rsp_count;
  int credit_back;

  lsu_top u_lsu_top (
    .clk        (clk),
    .nrst       (nrst),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .rsp_credit (rsp_credit),
    .req_credit (req_credit),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Counts returned input credits and collects responses
  always @(posedge clk) begin
    if (nrst) begin
      if (req_credit) begin
        req_back++;
      end
      if (rsp_valid) begin
        got_q.push_back(rsp_data);
        rsp_count++;
      end
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at time %0t", $time);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at time %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      fail_run($sformatf("mismatch at time %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  // Byte lane from bits 1:0, half from bit 1 and word from neither
  function automatic void store_to_model(input mem_op_e op, input word_t addr, input word_t data);
    int idx;
    int lane;
    idx  = int'(addr[7:2]);
    lane = int'(addr[1:0]);
    case (op)
      OP_SB:   model_mem[idx][8*lane +: 8] = data[7:0];
      OP_SH:   model_mem[idx][16*(lane/2) +: 16] = data[15:0];
      default: model_mem[idx] = data;
    endcase
  endfunction

  function automatic word_t load_from_model(input mem_op_e op, input word_t addr);
    word_t       w;
    logic [7:0]  b;
    logic [15:0] h;
    word_t       r;
    w = model_mem[int'(addr[7:2])];
    b = 8'(w >> (8 * int'(addr[1:0])));
    h = 16'(w >> (16 * int'(addr[1])));
    case (op)
      OP_LB:   r = {{24{b[7]}}, b};
      OP_LBU:  r = {24'h0, b};
      OP_LH:   r = {{16{h[15]}}, h};
      OP_LHU:  r = {16'h0, h};
      default: r = w;
    endcase
    return r;
  endfunction

  function automatic word_t fill_pattern(input word_t addr);
    return (addr * 32'h0101_0101) ^ 32'h80c0_a5f1;
  endfunction

  task automatic apply_reset();
    nrst = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    nrst = 1'b1;
  endtask

  // Drives one request for one cycle once an input credit is free
  task automatic send_req(input mem_op_e op, input word_t addr, input word_t wdata);
    int waited;
    waited = 0;
    while (req_sent - req_back >= REQ_DEPTH) begin
      if (waited >= WAIT_LIMIT) begin
        fail_run("timeout waiting for an input credit");
      end
      @(negedge clk);
      waited++;
    end
    req_valid = 1'b1;
    req_op    = op;
    req_addr  = addr;
    req_wdata = wdata;
    req_sent++;
    if (op inside {OP_SB, OP_SH, OP_SW}) begin
      store_to_model(op, addr, wdata);
    end else begin
      exp_q.push_back(load_from_model(op, addr));
      loads_sent++;
    end
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic pulse_credit();
    rsp_credit = 1'b1;
    credit_back++;
    @(negedge clk);
    rsp_credit = 1'b0;
  endtask

  // Returns credits until every request is done and every response paid back
  task automatic settle(input string what);
    int waited;
    waited = 0;
    while (rsp_count < loads_sent || credit_back != rsp_count || req_back < req_sent) begin
      if (waited >= WAIT_LIMIT) begin
        fail_run({"timeout waiting for responses in ", what});
      end
      if (credit_back < rsp_count) begin
        pulse_credit();
      end else begin
        @(negedge clk);
      end
      waited++;
    end
  endtask

  task automatic compare_responses(input string what);
    int n;
    n = 0;
    check_count({what, " returned input credits"}, req_back, req_sent);
    check_count({what, " response count"}, got_q.size(), exp_q.size());
    while (got_q.size() > 0) begin
      check_word($sformatf("%s rsp_data #%0d", what, n), got_q.pop_front(), exp_q.pop_front());
      n++;
    end
  endtask

  task automatic load_now(input mem_op_e op, input word_t addr, input string what);
    send_req(op, addr, 32'h0);
    settle(what);
  endtask

  task automatic idle_after_reset();
    repeat (8) @(negedge clk);
    check_count("rsp_valid pulses after reset", rsp_count, 0);
    check_count("req_credit pulses after reset", req_back, 0);
  endtask

  // Defined contents for every word before any load
  task automatic fill_memory();
    for (int i = 0; i < DMEM_WORDS; i++) begin
      send_req(OP_SW, word_t'(i * 4), fill_pattern(word_t'(i * 4)));
    end
    settle("memory fill");
  endtask

  task automatic word_store_load();
    send_req(OP_SW, 32'h0000_0040, 32'hdead_beef);
    send_req(OP_SW, 32'h0000_0044, 32'h1234_5678);
    load_now(OP_LW, 32'h0000_0040, "word store");
    // Upper address bits are not decoded
    load_now(OP_LW, 32'hffff_ff44, "word store");
    compare_responses("word store");
  endtask

  task automatic partial_store_merge();
    for (int lane = 0; lane < 4; lane++) begin
      send_req(OP_SW, 32'h0000_0050, 32'h0123_4567);
      send_req(OP_SB, word_t'(32'h50 + lane), word_t'(32'hffff_ffa0 + lane));
      load_now(OP_LW, 32'h0000_0050, "byte store");
    end
    // Odd address for the upper half since bit 0 is ignored
    for (int half = 0; half < 2; half++) begin
      send_req(OP_SW, 32'h0000_0054, 32'h89ab_cdef);
      send_req(OP_SH, word_t'(32'h54 + 3 * half), word_t'(32'h5a5a_0f10 + half));
      load_now(OP_LW, 32'h0000_0054, "half store");
    end
    compare_responses("partial store");
  endtask

  task automatic load_extension();
    send_req(OP_SW, 32'h0000_0060, 32'hf08c_a4d2);
    for (int lane = 0; lane < 4; lane++) begin
      load_now(OP_LB, word_t'(32'h60 + lane), "signed byte");
      load_now(OP_LBU, word_t'(32'h60 + lane), "unsigned byte");
    end
    for (int half = 0; half < 2; half++) begin
      load_now(OP_LH, word_t'(32'h60 + 2 * half), "signed half");
      load_now(OP_LHU, word_t'(32'h61 + 2 * half), "unsigned half");
    end
    compare_responses("load extension");
  endtask

  task automatic back_pressure();
    int base;
    int waited;
    base   = rsp_count;
    waited = 0;
    for (int i = 0; i < 5; i++) begin
      send_req(OP_LW, word_t'(32'h80 + 4 * i), 32'h0);
    end
    while (rsp_count - base < RSP_CREDITS) begin
      if (waited >= WAIT_LIMIT) begin
        fail_run("timeout waiting for the first responses under back-pressure");
      end
      @(negedge clk);
      waited++;
    end
    // Nothing else may come out while no credits are back
    repeat (10) @(negedge clk);
    check_count("responses without returned credits", rsp_count - base, RSP_CREDITS);
    settle("back-pressure");
    compare_responses("back-pressure");
  endtask

  task automatic random_mix();
    int      base_loads;
    int      base_rsp;
    int      waited;
    bit      sending_done;
    mem_op_e op;
    word_t   addr;
    word_t   wdata;
    base_loads   = loads_sent;
    base_rsp     = rsp_count;
    waited       = 0;
    sending_done = 1'b0;
    fork
      begin
        for (int i = 0; i < 40; i++) begin
          op    = mem_op_e'($urandom_range(7, 0));
          addr  = $urandom;
          wdata = $urandom;
          send_req(op, addr, wdata);
        end
        sending_done = 1'b1;
      end
      begin
        while (!sending_done || rsp_count < loads_sent || credit_back != rsp_count ||
               req_back < req_sent) begin
          if (waited >= WAIT_LIMIT * 4) begin
            fail_run("timeout in the random operation sequence");
          end
          if (credit_back < rsp_count && $urandom_range(1, 0) == 1) begin
            pulse_credit();
          end else begin
            @(negedge clk);
          end
          waited++;
        end
      end
    join
    check_count("random responses vs loads", rsp_count - base_rsp, loads_sent - base_loads);
    compare_responses("random mix");
  endtask

  initial begin
    nrst        = 1'b0;
    req_valid   = 1'b0;
    req_op      = OP_LW;
    req_addr    = '0;
    req_wdata   = '0;
    rsp_credit  = 1'b0;
    req_sent    = 0;
    req_back    = 0;
    loads_sent  = 0;
    rsp_count   = 0;
    credit_back = 0;
    void'($urandom(32'h82f6));
    apply_reset();
    idle_after_reset();
    fill_memory();
    word_store_load();
    partial_store_merge();
    load_extension();
    back_pressure();
    random_mix();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
